// File: Makefile
# Verilator build and run of the flash controller testbench

VERILATOR ?= verilator
TOP       ?= flash_ctrl_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "All tests passed" $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: rtl/flash_cmd_decode.sv
// command queue of CmdCredits entries; the host must hold a credit per command
// the head stays stable until retire_i pops it

`timescale 1ns/1ps

module flash_cmd_decode import flash_ctrl_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              cmd_valid_i,
  input  flash_op_e         cmd_op_i,
  input  flash_part_e       cmd_part_i,
  input  addr_t             cmd_addr_i,
  input  data_t             cmd_wdata_i,
  input  logic              retire_i,
  output logic              req_valid_o,
  output flash_op_e         req_op_o,
  output flash_part_e       req_part_o,
  output bank_t             req_bank_o,
  output logic [PageW-1:0]  req_page_o,
  output logic [WordW-1:0]  req_word_o,
  output data_t             req_wdata_o
);

  flash_op_e   op_mem    [CmdCredits];
  flash_part_e part_mem  [CmdCredits];
  addr_t       addr_mem  [CmdCredits];
  data_t       wdata_mem [CmdCredits];

  logic [CmdPtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CmdPtrW:0]   count_q;
  addr_t              head_addr;

  // pointer and fill level
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (cmd_valid_i) begin
        wr_ptr_q <= (wr_ptr_q == CmdPtrW'(CmdCredits - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (retire_i) begin
        rd_ptr_q <= (rd_ptr_q == CmdPtrW'(CmdCredits - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + (CmdPtrW + 1)'(cmd_valid_i) - (CmdPtrW + 1)'(retire_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_valid_i) begin
      op_mem[wr_ptr_q]    <= cmd_op_i;
      part_mem[wr_ptr_q]  <= cmd_part_i;
      addr_mem[wr_ptr_q]  <= cmd_addr_i;
      wdata_mem[wr_ptr_q] <= cmd_wdata_i;
    end
  end

  // head entry, address split into {bank, page, word}
  assign head_addr   = addr_mem[rd_ptr_q];
  assign req_valid_o = (count_q != '0);
  assign req_op_o    = op_mem[rd_ptr_q];
  assign req_part_o  = part_mem[rd_ptr_q];
  assign req_bank_o  = head_addr[AddrW-1 -: BankW];
  assign req_page_o  = head_addr[WordW +: PageW];
  assign req_word_o  = head_addr[WordW-1:0];
  assign req_wdata_o = wdata_mem[rd_ptr_q];

  // a command without a credit would overrun the queue
  no_write_when_full_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_valid_i |-> (count_q < (CmdPtrW + 1)'(CmdCredits)));

  // the result stage only retires an entry that is present
  retire_needs_head_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    retire_i |-> req_valid_o);

endmodule

// File: rtl/flash_ctrl_pkg.sv
// shared sizes, vector types and enums of the flash controller
// geometry is fixed here; address fields are packed as {bank, page, word}

package flash_ctrl_pkg;

  //////////////////////////////////////////////////
  // geometry
  //////////////////////////////////////////////////

  localparam int NumBanks     = 2;
  localparam int PagesPerBank = 16;
  localparam int InfoPages    = 2;
  localparam int WordsPerPage = 4;
  localparam int DataW        = 16;

  // address field widths
  localparam int BankW     = 1;
  localparam int PageW     = 4;
  localparam int WordW     = 2;
  localparam int AddrW     = 7;
  localparam int AllPagesW = 5;
  // info page index within a bank
  localparam int InfoPageW = 1;

  //////////////////////////////////////////////////
  // protection, queue and timing
  //////////////////////////////////////////////////

  // software regions, the default region comes on top
  localparam int MpRegions = 2;

  // queue depth equals the credits handed to the host
  localparam int CmdCredits = 2;
  localparam int CmdPtrW    = 1;

  // busy cycles per array operation
  localparam int ReadCycles    = 2;
  localparam int ProgCycles    = 3;
  localparam int PgEraseCycles = 4;
  localparam int BkEraseCycles = 8;
  localparam int CycleCntW     = 4;

  //////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////

  typedef logic [AddrW-1:0]     addr_t;
  typedef logic [DataW-1:0]     data_t;
  typedef logic [AllPagesW-1:0] page_addr_t;
  typedef logic [BankW-1:0]     bank_t;

  typedef enum logic [1:0] {
    OpRead,
    OpProg,
    OpPgErase,
    OpBkErase
  } flash_op_e;

  typedef enum logic {
    PartData,
    PartInfo
  } flash_part_e;

  // array model sequencing
  typedef enum logic [1:0] {
    PhyIdle,
    PhyBusy,
    PhyDone
  } phy_state_e;

endpackage

// File: rtl/flash_ctrl_top.sv
// flash controller top; host holds CmdCredits credits after reset
// responses are always accepted by the host and come back in command order

`timescale 1ns/1ps

module flash_ctrl_top import flash_ctrl_pkg::*; (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                cmd_valid_i,
  input  flash_op_e                           cmd_op_i,
  input  flash_part_e                         cmd_part_i,
  input  addr_t                               cmd_addr_i,
  input  data_t                               cmd_wdata_i,
  output logic                                cmd_credit_o,
  output logic                                rsp_valid_o,
  output logic                                rsp_err_o,
  output data_t                               rsp_rdata_o,
  input  logic [MpRegions-1:0]                region_en_i,
  input  logic [MpRegions-1:0]                region_rd_i,
  input  logic [MpRegions-1:0]                region_prog_i,
  input  logic [MpRegions-1:0]                region_erase_i,
  input  page_addr_t [MpRegions-1:0]          region_base_i,
  input  page_addr_t [MpRegions-1:0]          region_size_i,
  input  logic                                default_rd_i,
  input  logic                                default_prog_i,
  input  logic                                default_erase_i,
  input  logic [NumBanks-1:0][InfoPages-1:0]  info_rd_i,
  input  logic [NumBanks-1:0][InfoPages-1:0]  info_prog_i,
  input  logic [NumBanks-1:0][InfoPages-1:0]  info_erase_i,
  input  logic [NumBanks-1:0]                 bank_erase_en_i
);

  logic             req_valid;
  flash_op_e        req_op;
  flash_part_e      req_part;
  bank_t            req_bank;
  logic [PageW-1:0] req_page;
  logic [WordW-1:0] req_word;
  data_t            req_wdata;
  logic             phy_start, deny, exec_busy, phy_done, retire;
  data_t            phy_rdata;

  flash_cmd_decode u_decode (
    .clk_i, .rst_ni, .cmd_valid_i, .cmd_op_i, .cmd_part_i, .cmd_addr_i, .cmd_wdata_i,
    .retire_i(retire), .req_valid_o(req_valid), .req_op_o(req_op), .req_part_o(req_part),
    .req_bank_o(req_bank), .req_page_o(req_page), .req_word_o(req_word),
    .req_wdata_o(req_wdata)
  );

  flash_mp u_mp (
    .clk_i, .rst_ni, .req_valid_i(req_valid), .req_op_i(req_op), .req_part_i(req_part),
    .req_bank_i(req_bank), .req_page_i(req_page), .exec_busy_i(exec_busy),
    .region_en_i, .region_rd_i, .region_prog_i, .region_erase_i, .region_base_i,
    .region_size_i, .default_rd_i, .default_prog_i, .default_erase_i,
    .info_rd_i, .info_prog_i, .info_erase_i, .bank_erase_en_i,
    .phy_start_o(phy_start), .deny_o(deny)
  );

  // exec_busy comes straight from the array model
  flash_phy_model u_phy (
    .clk_i, .rst_ni, .start_i(phy_start), .op_i(req_op), .part_i(req_part),
    .bank_i(req_bank), .page_i(req_page), .word_i(req_word), .wdata_i(req_wdata),
    .busy_o(exec_busy), .done_o(phy_done), .rdata_o(phy_rdata)
  );

  flash_rsp u_rsp (
    .clk_i, .rst_ni, .phy_done_i(phy_done), .phy_rdata_i(phy_rdata), .deny_i(deny),
    .op_i(req_op), .rsp_valid_o, .rsp_err_o, .rsp_rdata_o, .retire_o(retire),
    .cmd_credit_o
  );

endmodule

// File: rtl/flash_mp.sv
// memory protection for the queue head; one start or deny per head
// regions apply to the data partition only; lowest matching region wins

`timescale 1ns/1ps

module flash_mp import flash_ctrl_pkg::*; (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  req_valid_i,
  input  flash_op_e                             req_op_i,
  input  flash_part_e                           req_part_i,
  input  bank_t                                 req_bank_i,
  input  logic [PageW-1:0]                      req_page_i,
  input  logic                                  exec_busy_i,
  input  logic [MpRegions-1:0]                  region_en_i,
  input  logic [MpRegions-1:0]                  region_rd_i,
  input  logic [MpRegions-1:0]                  region_prog_i,
  input  logic [MpRegions-1:0]                  region_erase_i,
  input  page_addr_t [MpRegions-1:0]            region_base_i,
  input  page_addr_t [MpRegions-1:0]            region_size_i,
  input  logic                                  default_rd_i,
  input  logic                                  default_prog_i,
  input  logic                                  default_erase_i,
  input  logic [NumBanks-1:0][InfoPages-1:0]    info_rd_i,
  input  logic [NumBanks-1:0][InfoPages-1:0]    info_prog_i,
  input  logic [NumBanks-1:0][InfoPages-1:0]    info_erase_i,
  input  logic [NumBanks-1:0]                   bank_erase_en_i,
  output logic                                  phy_start_o,
  output logic                                  deny_o
);

  page_addr_t            bank_page;
  logic [MpRegions-1:0]  match, win;
  logic                  rd_perm, prog_perm, erase_perm;
  logic [InfoPageW-1:0]  info_page;
  logic                  in_bounds;
  logic                  allowed;
  logic                  eval;
  logic                  held_q;

  assign bank_page = {req_bank_i, req_page_i};
  assign info_page = req_page_i[InfoPageW-1:0];

  //////////////////////////////////////////////////
  // bounds
  //////////////////////////////////////////////////

  always_comb begin
    if (int'(req_bank_i) >= NumBanks) begin
      in_bounds = 1'b0;
    end else if (req_part_i == PartData) begin
      in_bounds = int'(req_page_i) < PagesPerBank;
    end else begin
      in_bounds = int'(req_page_i) < InfoPages;
    end
  end

  //////////////////////////////////////////////////
  // data region select
  //////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < MpRegions; i++) begin
      match[i] = region_en_i[i] && (bank_page >= region_base_i[i]) &&
                 ({1'b0, bank_page} < ({1'b0, region_base_i[i]} + {1'b0, region_size_i[i]}));
    end
    // keep the lowest set bit only
    win = match & (~match + MpRegions'(1));

    rd_perm    = default_rd_i;
    prog_perm  = default_prog_i;
    erase_perm = default_erase_i;
    for (int i = 0; i < MpRegions; i++) begin
      if (win[i]) begin
        rd_perm    = region_rd_i[i];
        prog_perm  = region_prog_i[i];
        erase_perm = region_erase_i[i];
      end
    end
  end

  //////////////////////////////////////////////////
  // permission per op
  //////////////////////////////////////////////////

  always_comb begin
    allowed = 1'b0;
    if (req_part_i == PartData) begin
      unique case (req_op_i)
        OpRead:    allowed = rd_perm;
        OpProg:    allowed = prog_perm;
        OpPgErase: allowed = erase_perm;
        OpBkErase: allowed = bank_erase_en_i[req_bank_i];
        default:   allowed = 1'b0;
      endcase
    end else begin
      // bank erase never reaches the info partition
      unique case (req_op_i)
        OpRead:    allowed = info_rd_i[req_bank_i][info_page];
        OpProg:    allowed = info_prog_i[req_bank_i][info_page];
        OpPgErase: allowed = info_erase_i[req_bank_i][info_page];
        default:   allowed = 1'b0;
      endcase
    end
    allowed = allowed & in_bounds;
  end

  // held until the head is retired, which is one cycle after deny or after busy drops
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      held_q <= 1'b0;
    end else if (phy_start_o || deny_o) begin
      held_q <= 1'b1;
    end else if (!exec_busy_i) begin
      held_q <= 1'b0;
    end
  end

  assign eval        = req_valid_i & ~exec_busy_i & ~held_q;
  assign phy_start_o = eval & allowed;
  assign deny_o      = eval & ~allowed;

  start_deny_excl_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(phy_start_o && deny_o));

  // the region decision for a data command rests on known configuration
  region_win_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_valid_i && req_part_i == PartData) |-> !$isunknown(win));

endmodule

// File: rtl/flash_phy_model.sv
// behavioural flash array, not meant for synthesis into real flash
// all words reset to the erased value; program can only clear bits

`timescale 1ns/1ps

module flash_phy_model import flash_ctrl_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              start_i,
  input  flash_op_e         op_i,
  input  flash_part_e       part_i,
  input  bank_t             bank_i,
  input  logic [PageW-1:0]  page_i,
  input  logic [WordW-1:0]  word_i,
  input  data_t             wdata_i,
  output logic              busy_o,
  output logic              done_o,
  output data_t             rdata_o
);

  localparam int DataWords = NumBanks * PagesPerBank * WordsPerPage;
  localparam int InfoWords = NumBanks * InfoPages * WordsPerPage;

  data_t data_mem [DataWords];
  data_t info_mem [InfoWords];

  phy_state_e              state_q;
  logic [CycleCntW-1:0]    cnt_q, op_cycles;
  flash_op_e               op_q;
  flash_part_e             part_q;
  bank_t                   bank_q;
  logic [PageW-1:0]        page_q;
  logic [WordW-1:0]        word_q;
  data_t                   wdata_q, rdata_q;
  addr_t                   data_idx;
  logic [BankW+InfoPageW+WordW-1:0] info_idx;

  // latched at start, stable while busy
  always_ff @(posedge clk_i) begin
    if (start_i && state_q == PhyIdle) begin
      op_q    <= op_i;
      part_q  <= part_i;
      bank_q  <= bank_i;
      page_q  <= page_i;
      word_q  <= word_i;
      wdata_q <= wdata_i;
    end
  end

  assign data_idx = {bank_q, page_q, word_q};
  assign info_idx = {bank_q, page_q[InfoPageW-1:0], word_q};

  always_comb begin
    unique case (op_q)
      OpRead:    op_cycles = CycleCntW'(ReadCycles);
      OpProg:    op_cycles = CycleCntW'(ProgCycles);
      OpPgErase: op_cycles = CycleCntW'(PgEraseCycles);
      default:   op_cycles = CycleCntW'(BkEraseCycles);
    endcase
  end

  //////////////////////////////////////////////////
  // sequencing and array update
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= PhyIdle;
      cnt_q   <= '0;
      rdata_q <= '0;
      for (int i = 0; i < DataWords; i++) data_mem[i] <= '1;
      for (int i = 0; i < InfoWords; i++) info_mem[i] <= '1;
    end else begin
      unique case (state_q)
        PhyIdle: begin
          if (start_i) begin
            state_q <= PhyBusy;
            cnt_q   <= CycleCntW'(1);
          end
        end
        PhyBusy: begin
          if (cnt_q == op_cycles) begin
            state_q <= PhyDone;
            if (op_q == OpRead) begin
              rdata_q <= (part_q == PartData) ? data_mem[data_idx] : info_mem[info_idx];
            end else if (op_q == OpProg && part_q == PartData) begin
              data_mem[data_idx] <= data_mem[data_idx] & wdata_q;
            end else if (op_q == OpProg) begin
              info_mem[info_idx] <= info_mem[info_idx] & wdata_q;
            end else if (op_q == OpPgErase && part_q == PartData) begin
              for (int w = 0; w < WordsPerPage; w++) begin
                data_mem[{bank_q, page_q, WordW'(w)}] <= '1;
              end
            end else if (op_q == OpPgErase) begin
              for (int w = 0; w < WordsPerPage; w++) begin
                info_mem[{bank_q, page_q[InfoPageW-1:0], WordW'(w)}] <= '1;
              end
            end else begin
              // bank erase covers the data partition of one bank
              for (int k = 0; k < PagesPerBank * WordsPerPage; k++) begin
                data_mem[{bank_q, (PageW + WordW)'(k)}] <= '1;
              end
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        PhyDone: state_q <= PhyIdle;
        default: state_q <= PhyIdle;
      endcase
    end
  end

  assign busy_o  = (state_q != PhyIdle);
  assign done_o  = (state_q == PhyDone);
  assign rdata_o = rdata_q;

  no_start_when_busy_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_i |-> !busy_o);

endmodule

// File: rtl/flash_rsp.sv
// response register; one response, one retire and one credit per command
// read data is zero unless the command was an allowed read

`timescale 1ns/1ps

module flash_rsp import flash_ctrl_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       phy_done_i,
  input  data_t      phy_rdata_i,
  input  logic       deny_i,
  input  flash_op_e  op_i,
  output logic       rsp_valid_o,
  output logic       rsp_err_o,
  output data_t      rsp_rdata_o,
  output logic       retire_o,
  output logic       cmd_credit_o
);

  logic  valid_q;
  logic  err_q;
  data_t rdata_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      err_q   <= 1'b0;
      rdata_q <= '0;
    end else begin
      valid_q <= phy_done_i | deny_i;
      err_q   <= deny_i;
      // op_i is still the head here, retire has not happened yet
      rdata_q <= (phy_done_i && op_i == OpRead) ? phy_rdata_i : '0;
    end
  end

  assign rsp_valid_o  = valid_q;
  assign rsp_err_o    = err_q;
  assign rsp_rdata_o  = rdata_q;

  // the entry leaves the queue and its credit goes back with the response
  assign retire_o     = valid_q;
  assign cmd_credit_o = valid_q;

  single_source_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(deny_i && phy_done_i));

endmodule

// File: testbench/flash_ctrl_tb.sv
// testbench for the flash controller with one fixed protection setup for the whole run
// expected results come from a reference array and the configured permissions

`timescale 1ns/1ps

module flash_ctrl_tb import flash_ctrl_pkg::*; ();

  localparam int MaxEntries = 32;
  localparam int Timeout    = 100;
  localparam int Reg0Base   = 2;
  localparam int Reg0Size   = 4;
  localparam int Reg1Base   = 4;
  localparam int Reg1Size   = 6;

  logic                               clk_i, rst_ni;
  logic                               cmd_valid_i;
  flash_op_e                          cmd_op_i;
  flash_part_e                        cmd_part_i;
  addr_t                              cmd_addr_i;
  data_t                              cmd_wdata_i;
  logic                               cmd_credit_o, rsp_valid_o, rsp_err_o;
  data_t                              rsp_rdata_o;
  logic [MpRegions-1:0]               region_en_i, region_rd_i, region_prog_i, region_erase_i;
  page_addr_t [MpRegions-1:0]         region_base_i, region_size_i;
  logic                               default_rd_i, default_prog_i, default_erase_i;
  logic [NumBanks-1:0][InfoPages-1:0] info_rd_i, info_prog_i, info_erase_i;
  logic [NumBanks-1:0]                bank_erase_en_i;

  // reference array, same erased state as the flash after reset
  data_t ref_data [NumBanks*PagesPerBank*WordsPerPage];
  data_t ref_info [NumBanks*InfoPages*WordsPerPage];

  string       tbl_name  [MaxEntries];
  flash_op_e   tbl_op    [MaxEntries];
  flash_part_e tbl_part  [MaxEntries];
  addr_t       tbl_addr  [MaxEntries];
  data_t       tbl_wdata [MaxEntries];
  logic        tbl_err   [MaxEntries];
  data_t       tbl_rdata [MaxEntries];
  int          sent_cycle [MaxEntries];
  int          num_entries, burst_from, latency_idx;
  int          pending [$];

  flash_ctrl_top DUT (.*);

  always #5 clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // checking
  //////////////////////////////////////////////////

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      stop_run($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  function automatic addr_t word_addr(input int bank, input int page, input int word);
    return {bank[BankW-1:0], page[PageW-1:0], word[WordW-1:0]};
  endfunction

  // permissions of the fixed setup, region 0 is looked at first
  function automatic logic is_allowed(input flash_op_e op, input flash_part_e part,
                                      input addr_t addr);
    int bank;
    int page;
    int bank_page;
    bank      = int'(addr[AddrW-1 -: BankW]);
    page      = int'(addr[WordW +: PageW]);
    bank_page = int'(addr[AddrW-1:WordW]);
    if (part == PartInfo) begin
      if (page >= InfoPages || op == OpBkErase) begin
        return 1'b0;
      end
      return (op == OpRead) || (bank == 0 && page == 0);
    end
    if (op == OpBkErase) begin
      return bank == 0;
    end
    if (bank_page >= Reg0Base && bank_page < Reg0Base + Reg0Size) begin
      return op != OpPgErase;
    end
    if (bank_page >= Reg1Base && bank_page < Reg1Base + Reg1Size) begin
      return 1'b1;
    end
    return op == OpRead;
  endfunction

  // adds one row and predicts its response from the reference array
  task automatic add_entry(input string name, input flash_op_e op, input flash_part_e part,
                           input addr_t addr, input data_t wdata);
    int n;
    int pg_base;
    int info_idx;
    n        = num_entries;
    pg_base  = int'(addr) - int'(addr[WordW-1:0]);
    info_idx = int'(addr[AddrW-1 -: BankW]) * InfoPages * WordsPerPage +
               int'(addr[WordW +: PageW]) * WordsPerPage + int'(addr[WordW-1:0]);
    tbl_name[n]  = name;
    tbl_op[n]    = op;
    tbl_part[n]  = part;
    tbl_addr[n]  = addr;
    tbl_wdata[n] = wdata;
    tbl_err[n]   = !is_allowed(op, part, addr);
    tbl_rdata[n] = '0;
    if (!tbl_err[n]) begin
      case (op)
        OpRead: tbl_rdata[n] = (part == PartData) ? ref_data[int'(addr)] : ref_info[info_idx];
        OpProg: begin
          if (part == PartData) ref_data[int'(addr)] = ref_data[int'(addr)] & wdata;
          else ref_info[info_idx] = ref_info[info_idx] & wdata;
        end
        OpPgErase: begin
          for (int w = 0; w < WordsPerPage; w++) begin
            if (part == PartData) ref_data[pg_base + w] = '1;
            else ref_info[info_idx - int'(addr[WordW-1:0]) + w] = '1;
          end
        end
        default: begin
          for (int k = 0; k < PagesPerBank * WordsPerPage; k++) begin
            ref_data[int'(addr[AddrW-1 -: BankW]) * PagesPerBank * WordsPerPage + k] = '1;
          end
        end
      endcase
    end
    num_entries++;
  endtask

  task automatic build_table();
    add_entry("erase region 1 page", OpPgErase, PartData, word_addr(0, 6, 0), 16'h0000);
    add_entry("program region 1 word", OpProg, PartData, word_addr(0, 6, 1), 16'hA5F0);
    add_entry("read region 1 word", OpRead, PartData, word_addr(0, 6, 1), 16'h0000);
    add_entry("program again region 1", OpProg, PartData, word_addr(0, 6, 1), 16'h0FFF);
    add_entry("read again region 1", OpRead, PartData, word_addr(0, 6, 1), 16'h0000);
    // page 4 sits in both regions and region 0 has no erase right
    add_entry("program overlap", OpProg, PartData, word_addr(0, 4, 0), 16'h3C3C);
    add_entry("erase overlap", OpPgErase, PartData, word_addr(0, 4, 0), 16'h0000);
    add_entry("program default page", OpProg, PartData, word_addr(0, 12, 0), 16'h0000);
    add_entry("read default page", OpRead, PartData, word_addr(0, 12, 0), 16'h0000);
    add_entry("read overlap", OpRead, PartData, word_addr(0, 4, 0), 16'h0000);
    add_entry("erase bank 0", OpBkErase, PartData, word_addr(0, 0, 0), 16'h0000);
    add_entry("read after bank erase", OpRead, PartData, word_addr(0, 6, 1), 16'h0000);
    add_entry("read overlap after erase", OpRead, PartData, word_addr(0, 4, 0), 16'h0000);
    add_entry("erase bank 1", OpBkErase, PartData, word_addr(1, 0, 0), 16'h0000);
    add_entry("erase info bank", OpBkErase, PartInfo, word_addr(0, 0, 0), 16'h0000);
    add_entry("program info page 0", OpProg, PartInfo, word_addr(0, 0, 2), 16'h1234);
    add_entry("read info page 0", OpRead, PartInfo, word_addr(0, 0, 2), 16'h0000);
    add_entry("program info page 1", OpProg, PartInfo, word_addr(0, 1, 0), 16'h0000);
    add_entry("read info out of range", OpRead, PartInfo, word_addr(0, 2, 0), 16'h0000);
    add_entry("read info bank 1", OpRead, PartInfo, word_addr(1, 1, 3), 16'h0000);
    // back to back from here on
    burst_from = num_entries;
    add_entry("burst program", OpProg, PartData, word_addr(0, 8, 3), 16'h00FF);
    add_entry("burst read", OpRead, PartData, word_addr(0, 8, 3), 16'h0000);
    add_entry("burst denied program", OpProg, PartData, word_addr(1, 3, 0), 16'h0000);
    add_entry("burst info read", OpRead, PartInfo, word_addr(0, 0, 2), 16'h0000);
    add_entry("burst read again", OpRead, PartData, word_addr(0, 8, 3), 16'h0000);
    latency_idx = num_entries;
    add_entry("idle deny latency", OpProg, PartData, word_addr(1, 3, 1), 16'h0000);
  endtask

  task automatic sample_outputs(input int cycle);
    int idx;
    check_value("credit with response", 32'(rsp_valid_o), 32'(cmd_credit_o));
    if (rsp_valid_o) begin
      if (pending.size() == 0) begin
        stop_run("a response arrived with no command outstanding");
      end else begin
        idx = pending.pop_front();
        check_value({tbl_name[idx], " error"}, 32'(tbl_err[idx]), 32'(rsp_err_o));
        check_value({tbl_name[idx], " read data"}, 32'(tbl_rdata[idx]), 32'(rsp_rdata_o));
        if (idx == latency_idx) begin
          check_value(tbl_name[idx], 32'd2, 32'(cycle - sent_cycle[idx]));
        end
      end
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial begin
    int   next_idx, gap, credits, cycle, idle_cycles;
    logic credit_back, saw_exhaust;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    cmd_valid_i = 1'b0;
    cmd_op_i = OpRead;
    cmd_part_i = PartData;
    cmd_addr_i = '0;
    cmd_wdata_i = '0;
    region_en_i = 2'b11;
    region_rd_i = 2'b11;
    region_prog_i = 2'b11;
    region_erase_i = 2'b10;
    region_base_i[0] = page_addr_t'(Reg0Base);
    region_size_i[0] = page_addr_t'(Reg0Size);
    region_base_i[1] = page_addr_t'(Reg1Base);
    region_size_i[1] = page_addr_t'(Reg1Size);
    default_rd_i = 1'b1;
    default_prog_i = 1'b0;
    default_erase_i = 1'b0;
    info_rd_i = '1;
    info_prog_i = '0;
    info_erase_i = '0;
    info_prog_i[0][0] = 1'b1;
    info_erase_i[0][0] = 1'b1;
    bank_erase_en_i = 2'b01;
    ref_data = '{default: '1};
    ref_info = '{default: '1};
    void'($urandom(32'h73162247));
    num_entries = 0;
    build_table();

    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;

    next_idx = 0;
    gap = 0;
    credits = CmdCredits;
    cycle = 0;
    idle_cycles = 0;
    saw_exhaust = 1'b0;
    while (next_idx < num_entries || pending.size() != 0) begin
      @(negedge clk_i);
      cycle++;
      idle_cycles++;
      cmd_valid_i = 1'b0;
      // a returned credit can be spent from the next cycle on
      credit_back = cmd_credit_o;
      if (rsp_valid_o) idle_cycles = 0;
      sample_outputs(cycle);
      if (next_idx < num_entries && credits > 0 && gap == 0 &&
          (next_idx != latency_idx || (credits == CmdCredits && pending.size() == 0))) begin
        cmd_valid_i = 1'b1;
        cmd_op_i = tbl_op[next_idx];
        cmd_part_i = tbl_part[next_idx];
        cmd_addr_i = tbl_addr[next_idx];
        cmd_wdata_i = tbl_wdata[next_idx];
        pending.push_back(next_idx);
        sent_cycle[next_idx] = cycle;
        credits--;
        if (credits == 0) saw_exhaust = 1'b1;
        next_idx++;
        gap = (next_idx < burst_from) ? int'($urandom_range(0, 3)) : 0;
      end else if (gap > 0) begin
        gap--;
      end
      if (credit_back) credits++;
      if (credits > CmdCredits) stop_run("the host holds more credits than the queue depth");
      if (idle_cycles > Timeout) stop_run("timed out waiting for a response");
    end

    check_value("credits exhausted in burst", 32'd1, 32'(saw_exhaust));
    check_value("credits after drain", 32'(CmdCredits), 32'(credits));
    $display("All tests passed");
    $finish;
  end

endmodule

// File: vlog.f
rtl/flash_ctrl_pkg.sv
rtl/flash_cmd_decode.sv
rtl/flash_mp.sv
rtl/flash_phy_model.sv
rtl/flash_rsp.sv
rtl/flash_ctrl_top.sv
testbench/flash_ctrl_tb.sv
